/* bert_pkg.sv */
package bert_pkg;

	//////////////////////////////////////////////////////////////////////
	// Line and block geometry

	// Parallel word from the receiver, one per lane0_rxclk
	localparam int RX_WIDTH = 32;

	// Whole 64b/66b block, split in two for the demux
	localparam int BLOCK_WIDTH = 66;
	localparam int HALF_WIDTH = BLOCK_WIDTH / 2;
	localparam int HDR_WIDTH = 2;
	localparam int PAYLOAD_WIDTH = BLOCK_WIDTH - HDR_WIDTH;

	// Sync header that fires the logic analyzer
	localparam logic [HDR_WIDTH-1:0] TRIGGER_HEADER = 2'b01;

	//////////////////////////////////////////////////////////////////////
	// Register bus

	localparam int AXI_ADDR_WIDTH = 8;
	localparam int AXI_DATA_WIDTH = 32;

	// Control, bit 0 arms the analyzer
	localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL = 8'h00;
	// Status, {done, armed, lock} in bits 2..0
	localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS = 8'h04;
	// Capture window, one word every 4 bytes
	localparam logic [AXI_ADDR_WIDTH-1:0] CAPTURE_BASE = 8'h80;

	//////////////////////////////////////////////////////////////////////
	// Default sizes, overridden from the top level

	localparam int DEF_CAPTURE_DEPTH = 32;
	localparam int DEF_LOCK_COUNT = 32;
	localparam int DEF_BAD_LIMIT = 8;
	localparam int DEF_SLIP_WAIT = 4;

	// One received block, seen either as header and payload or as two halves
	typedef union packed {
		struct packed {
			logic [HDR_WIDTH-1:0] header;
			logic [PAYLOAD_WIDTH-1:0] payload;
		} hdr_pl;
		struct packed {
			logic [HALF_WIDTH-1:0] upper;
			logic [HALF_WIDTH-1:0] lower;
		} halves;
	} block_word_u;

endpackage

/* rx_gearbox.sv */
`timescale 1ns/10ps

module rx_gearbox (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic [bert_pkg::RX_WIDTH-1:0] rx_data,
	input logic bitslip,
	output logic block_valid,
	output bert_pkg::block_word_u block
);

	// Leftover never exceeds one input word
	localparam int CNT_W = $clog2(bert_pkg::RX_WIDTH + 1);
	localparam int TOT_W = CNT_W + 1;

	// Leftover bits, valid ones at the bottom, oldest highest
	logic [bert_pkg::RX_WIDTH-1:0] acc;
	logic [CNT_W-1:0] cnt;

	// Leftover plus new word, and how many of those bits count
	logic [2*bert_pkg::RX_WIDTH-1:0] merged;
	logic [TOT_W-1:0] total;

	// Gearbox output towards the demux
	logic [bert_pkg::HALF_WIDTH-1:0] half;
	logic half_valid;

	// Low for the upper half, high for the lower half
	logic phase;

	//////////////////////////////////////////////////////////////////////
	// 32 to 33 gearbox

	always_comb begin
		merged = {acc, rx_data};
		// Bitslip throws away the oldest bit
		total = TOT_W'(cnt) + TOT_W'(bert_pkg::RX_WIDTH) - TOT_W'(bitslip);
	end

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			half_valid <= 1'b0;
		end else if (total >= TOT_W'(bert_pkg::HALF_WIDTH)) begin
			cnt <= CNT_W'(total - TOT_W'(bert_pkg::HALF_WIDTH));
			half_valid <= 1'b1;
		end else begin
			// Not enough for a half yet
			cnt <= CNT_W'(total);
			half_valid <= 1'b0;
		end
	end

	always_ff @(posedge lane0_rxclk) begin
		// What is left over always sits inside the newest word
		acc <= rx_data;
		// Oldest 33 bits go out, first received bit as MSB
		if (total >= TOT_W'(bert_pkg::HALF_WIDTH)) begin
			half <= merged[total-1 -: bert_pkg::HALF_WIDTH];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// 33 to 66 demux

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= 1'b0;
			block_valid <= 1'b0;
		end else begin
			block_valid <= 1'b0;
			if (half_valid) begin
				phase <= !phase;
				// Block complete once the lower half lands
				block_valid <= phase;
			end
		end
	end

	always_ff @(posedge lane0_rxclk) begin
		if (half_valid) begin
			if (phase) begin
				block.halves.lower <= half;
			end else begin
				block.halves.upper <= half;
			end
		end
	end

endmodule

/* block_aligner.sv */
`timescale 1ns/10ps

module block_aligner #(
	parameter int LOCK_COUNT = bert_pkg::DEF_LOCK_COUNT,
	parameter int BAD_LIMIT = bert_pkg::DEF_BAD_LIMIT,
	parameter int SLIP_WAIT = bert_pkg::DEF_SLIP_WAIT
) (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic block_valid,
	input logic [bert_pkg::HDR_WIDTH-1:0] header,
	output logic bitslip,
	output logic block_lock
);

	localparam int GOOD_W = $clog2(LOCK_COUNT + 1);
	localparam int BAD_W = $clog2(BAD_LIMIT + 1);
	localparam int WAIT_W = $clog2(SLIP_WAIT + 1);

	logic [GOOD_W-1:0] good_cnt;
	logic [BAD_W-1:0] bad_cnt;
	logic [WAIT_W-1:0] wait_cnt;
	// Bad header window, 64 blocks, wraps by itself
	logic [5:0] win_cnt;
	logic hdr_ok;

	// Only 01 and 10 are legal headers
	assign hdr_ok = header[1] ^ header[0];

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			bitslip <= 1'b0;
			block_lock <= 1'b0;
			good_cnt <= '0;
			bad_cnt <= '0;
			wait_cnt <= '0;
			win_cnt <= '0;
		end else begin
			bitslip <= 1'b0;
			if (block_valid) begin
				if (block_lock) begin
					win_cnt <= win_cnt + 6'd1;
					if (!hdr_ok && bad_cnt == BAD_W'(BAD_LIMIT - 1)) begin
						// Too many errors, back to hunting
						block_lock <= 1'b0;
						good_cnt <= '0;
						bad_cnt <= '0;
						win_cnt <= '0;
					end else if (win_cnt == 6'd63) begin
						// New window starts with this block
						bad_cnt <= BAD_W'(!hdr_ok);
					end else if (!hdr_ok) begin
						bad_cnt <= bad_cnt + 1'b1;
					end
				end else if (wait_cnt != '0) begin
					// Let the slipped data flush through
					wait_cnt <= wait_cnt - 1'b1;
				end else if (!hdr_ok) begin
					bitslip <= 1'b1;
					good_cnt <= '0;
					wait_cnt <= WAIT_W'(SLIP_WAIT);
				end else if (good_cnt == GOOD_W'(LOCK_COUNT - 1)) begin
					block_lock <= 1'b1;
					good_cnt <= '0;
					bad_cnt <= '0;
					win_cnt <= '0;
				end else begin
					good_cnt <= good_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* descrambler.sv */
`timescale 1ns/10ps

module descrambler (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic block_valid,
	input bert_pkg::block_word_u block,
	output logic payload_valid,
	output logic [bert_pkg::HDR_WIDTH-1:0] header,
	output logic [bert_pkg::PAYLOAD_WIDTH-1:0] payload
);

	// Taps for x^39 and x^58, index 0 is the newest bit
	localparam int TAP_A = 38;
	localparam int TAP_B = 57;

	logic [57:0] state;
	logic [57:0] state_nxt;
	logic [bert_pkg::PAYLOAD_WIDTH-1:0] clear;

	// Self-synchronizing, history is the scrambled line bits
	always_comb begin
		state_nxt = state;
		for (int i = 0; i < bert_pkg::PAYLOAD_WIDTH; i++) begin
			clear[i] = block.hdr_pl.payload[i] ^ state_nxt[TAP_A] ^ state_nxt[TAP_B];
			state_nxt = {state_nxt[56:0], block.hdr_pl.payload[i]};
		end
	end

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			payload_valid <= 1'b0;
		end else begin
			payload_valid <= block_valid;
		end
	end

	// Header rides along unscrambled
	always_ff @(posedge lane0_rxclk) begin
		if (block_valid) begin
			state <= state_nxt;
			header <= block.hdr_pl.header;
			payload <= clear;
		end
	end

endmodule

/* la_capture.sv */
`timescale 1ns/10ps

module la_capture #(
	parameter int CAPTURE_DEPTH = bert_pkg::DEF_CAPTURE_DEPTH
) (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic arm,
	input logic payload_valid,
	input logic [bert_pkg::HDR_WIDTH-1:0] header,
	input logic [bert_pkg::PAYLOAD_WIDTH-1:0] payload,
	input logic block_lock,
	output logic wr_req,
	output logic [$clog2(CAPTURE_DEPTH)-1:0] wr_addr,
	output logic [bert_pkg::PAYLOAD_WIDTH/2-1:0] wr_data,
	output logic armed,
	output logic done
);

	localparam int AW = $clog2(CAPTURE_DEPTH);
	localparam int WW = bert_pkg::PAYLOAD_WIDTH / 2;

	logic capturing;
	// Upper word waits one cycle behind the lower
	logic hi_pending;
	logic [WW-1:0] hi_word;
	logic [AW-1:0] wr_ptr;
	logic take;

	// Trigger block, or any block once the capture runs
	assign take = payload_valid && armed && !hi_pending &&
		(capturing || (block_lock && header == bert_pkg::TRIGGER_HEADER));

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			armed <= 1'b0;
			done <= 1'b0;
			capturing <= 1'b0;
			hi_pending <= 1'b0;
			wr_req <= 1'b0;
			wr_ptr <= '0;
			wr_addr <= '0;
		end else begin
			wr_req <= 1'b0;
			if (arm) begin
				// Fresh capture from word 0
				armed <= 1'b1;
				done <= 1'b0;
				capturing <= 1'b0;
				hi_pending <= 1'b0;
				wr_ptr <= '0;
			end else if (hi_pending) begin
				wr_req <= 1'b1;
				wr_addr <= wr_ptr;
				wr_ptr <= wr_ptr + 1'b1;
				hi_pending <= 1'b0;
				if (wr_ptr == AW'(CAPTURE_DEPTH - 1)) begin
					done <= 1'b1;
					armed <= 1'b0;
					capturing <= 1'b0;
				end
			end else if (take) begin
				wr_req <= 1'b1;
				wr_addr <= wr_ptr;
				wr_ptr <= wr_ptr + 1'b1;
				hi_pending <= 1'b1;
				capturing <= 1'b1;
			end
		end
	end

	// Low word first, high word on the next cycle
	always_ff @(posedge lane0_rxclk) begin
		if (hi_pending) begin
			wr_data <= hi_word;
		end else if (take) begin
			wr_data <= payload[WW-1:0];
			hi_word <= payload[2*WW-1:WW];
		end
	end

endmodule

/* capture_ram_arbiter.sv */
`timescale 1ns/10ps

module capture_ram_arbiter #(
	parameter int CAPTURE_DEPTH = bert_pkg::DEF_CAPTURE_DEPTH
) (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic wr_req,
	input logic [$clog2(CAPTURE_DEPTH)-1:0] wr_addr,
	input logic [bert_pkg::AXI_DATA_WIDTH-1:0] wr_data,
	input logic rd_req,
	input logic [$clog2(CAPTURE_DEPTH)-1:0] rd_addr,
	output logic rd_grant,
	output logic [bert_pkg::AXI_DATA_WIDTH-1:0] rd_data,
	output logic rd_data_valid
);

	// Single port, one access per cycle
	logic [bert_pkg::AXI_DATA_WIDTH-1:0] mem [CAPTURE_DEPTH];

	// Capture writes cannot stall, so they always win
	assign rd_grant = rd_req && !wr_req;

	//////////////////////////////////////////////////////////////////////
	// RAM port

	always_ff @(posedge lane0_rxclk) begin
		if (wr_req) begin
			mem[wr_addr] <= wr_data;
		end else if (rd_grant) begin
			rd_data <= mem[rd_addr];
		end
	end

	// Read data one cycle after the grant
	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			rd_data_valid <= 1'b0;
		end else begin
			rd_data_valid <= rd_grant;
		end
	end

endmodule

/* axil_regs.sv */
`timescale 1ns/10ps

module axil_regs #(
	parameter int CAPTURE_DEPTH = bert_pkg::DEF_CAPTURE_DEPTH
) (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic [bert_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [bert_pkg::AXI_DATA_WIDTH-1:0] wdata,
	input logic [bert_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [bert_pkg::AXI_ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [bert_pkg::AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic block_lock,
	input logic armed,
	input logic done,
	output logic arm,
	output logic rd_req,
	output logic [$clog2(CAPTURE_DEPTH)-1:0] rd_addr,
	input logic rd_grant,
	input logic [bert_pkg::AXI_DATA_WIDTH-1:0] rd_data,
	input logic rd_data_valid
);

	localparam int AW = $clog2(CAPTURE_DEPTH);
	localparam int DW = bert_pkg::AXI_DATA_WIDTH;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic idle;
	logic wr_fire;
	logic rd_fire;
	// Capture read waiting on the RAM
	logic cap_pend;
	logic [bert_pkg::AXI_ADDR_WIDTH-1:0] cap_off;
	logic [bert_pkg::AXI_ADDR_WIDTH-3:0] cap_word;
	logic cap_hit;

	// One transaction in flight at a time
	assign idle = !bvalid && !rvalid && !cap_pend && !awready && !arready;
	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	// Word index inside the capture window
	assign cap_off = araddr - bert_pkg::CAPTURE_BASE;
	assign cap_word = cap_off[bert_pkg::AXI_ADDR_WIDTH-1:2];
	assign cap_hit = (araddr >= bert_pkg::CAPTURE_BASE) && (cap_word < CAPTURE_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// Handshakes and responses

	always_ff @(posedge lane0_rxclk or negedge arst_n) begin
		if (!arst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			rvalid <= 1'b0;
			rresp <= RESP_OKAY;
			arm <= 1'b0;
			rd_req <= 1'b0;
			cap_pend <= 1'b0;
		end else begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			arm <= 1'b0;

			// AW and W only together, writes ahead of reads
			if (idle && awvalid && wvalid) begin
				awready <= 1'b1;
				wready <= 1'b1;
			end else if (idle && arvalid) begin
				arready <= 1'b1;
			end

			// Write decode
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					bert_pkg::REG_CTRL: begin
						bresp <= RESP_OKAY;
						arm <= wstrb[0] && wdata[0];
					end
					// Status is read only, write ignored
					bert_pkg::REG_STATUS: bresp <= RESP_OKAY;
					default: bresp <= RESP_SLVERR;
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end

			// Read decode, capture reads go through the arbiter
			if (rd_fire) begin
				if (araddr == bert_pkg::REG_CTRL || araddr == bert_pkg::REG_STATUS) begin
					rvalid <= 1'b1;
					rresp <= RESP_OKAY;
				end else if (cap_hit) begin
					rd_req <= 1'b1;
					cap_pend <= 1'b1;
				end else begin
					rvalid <= 1'b1;
					rresp <= RESP_SLVERR;
				end
			end else if (cap_pend && rd_data_valid) begin
				rvalid <= 1'b1;
				rresp <= RESP_OKAY;
				cap_pend <= 1'b0;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end

			// Request held until the arbiter takes it
			if (rd_req && rd_grant) begin
				rd_req <= 1'b0;
			end
		end
	end

	// Read data path
	always_ff @(posedge lane0_rxclk) begin
		if (rd_fire) begin
			rd_addr <= cap_word[AW-1:0];
			if (araddr == bert_pkg::REG_STATUS) begin
				rdata <= DW'({done, armed, block_lock});
			end else begin
				rdata <= '0;
			end
		end else if (cap_pend && rd_data_valid) begin
			rdata <= rd_data;
		end
	end

endmodule

/* bert_rx_top.sv */
`timescale 1ns/10ps

module bert_rx_top #(
	parameter int CAPTURE_DEPTH = bert_pkg::DEF_CAPTURE_DEPTH,
	parameter int LOCK_COUNT = bert_pkg::DEF_LOCK_COUNT,
	parameter int BAD_LIMIT = bert_pkg::DEF_BAD_LIMIT,
	parameter int SLIP_WAIT = bert_pkg::DEF_SLIP_WAIT
) (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic [bert_pkg::RX_WIDTH-1:0] rx_data,
	input logic [bert_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [bert_pkg::AXI_DATA_WIDTH-1:0] wdata,
	input logic [bert_pkg::AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [bert_pkg::AXI_ADDR_WIDTH-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [bert_pkg::AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	localparam int AW = $clog2(CAPTURE_DEPTH);

	// Gearbox and aligner
	bert_pkg::block_word_u rx_block;
	logic rx_block_valid;
	logic bitslip;
	logic block_lock;

	// Descrambled blocks
	logic pl_valid;
	logic [bert_pkg::HDR_WIDTH-1:0] pl_header;
	logic [bert_pkg::PAYLOAD_WIDTH-1:0] pl_payload;

	// Analyzer control and capture RAM ports
	logic arm;
	logic armed;
	logic done;
	logic wr_req;
	logic [AW-1:0] wr_addr;
	logic [bert_pkg::AXI_DATA_WIDTH-1:0] wr_data;
	logic rd_req;
	logic [AW-1:0] rd_addr;
	logic rd_grant;
	logic [bert_pkg::AXI_DATA_WIDTH-1:0] rd_data;
	logic rd_data_valid;

	//////////////////////////////////////////////////////////////////////
	// 64b/66b receive chain

	rx_gearbox u_gearbox (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.bitslip(bitslip),
		.block_valid(rx_block_valid),
		.block(rx_block)
	);

	block_aligner #(
		.LOCK_COUNT(LOCK_COUNT),
		.BAD_LIMIT(BAD_LIMIT),
		.SLIP_WAIT(SLIP_WAIT)
	) u_aligner (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.block_valid(rx_block_valid),
		.header(rx_block.hdr_pl.header),
		.bitslip(bitslip),
		.block_lock(block_lock)
	);

	descrambler u_descr (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.block_valid(rx_block_valid),
		.block(rx_block),
		.payload_valid(pl_valid),
		.header(pl_header),
		.payload(pl_payload)
	);

	//////////////////////////////////////////////////////////////////////
	// Logic analyzer and register bus

	la_capture #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) u_capture (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.arm(arm),
		.payload_valid(pl_valid),
		.header(pl_header),
		.payload(pl_payload),
		.block_lock(block_lock),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.armed(armed),
		.done(done)
	);

	capture_ram_arbiter #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) u_arbiter (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_grant(rd_grant),
		.rd_data(rd_data),
		.rd_data_valid(rd_data_valid)
	);

	axil_regs #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) u_regs (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.block_lock(block_lock),
		.armed(armed),
		.done(done),
		.arm(arm),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_grant(rd_grant),
		.rd_data(rd_data),
		.rd_data_valid(rd_data_valid)
	);

endmodule

/* tb_checker.sv */
`timescale 1ns/10ps

module tb_checker #(
	parameter int RESP_LIMIT = 40
) (
	input logic lane0_rxclk,
	input logic arst_n,
	input logic bvalid,
	input logic bready,
	input logic [1:0] bresp,
	input logic rvalid,
	input logic rready,
	input logic [1:0] rresp,
	input logic [bert_pkg::AXI_DATA_WIDTH-1:0] rdata
);

	// Expected response for the one transaction in flight
	logic pending;
	logic exp_is_read;
	logic [1:0] exp_resp;
	logic [31:0] exp_data;
	logic [31:0] exp_mask;
	string exp_name;
	int wait_cycles;

	// Last read data, used by the status poll
	logic [31:0] last_rdata;

	int value_errors;
	int missing_errors;
	int other_errors;

	initial begin
		pending = 1'b0;
		wait_cycles = 0;
		last_rdata = '0;
		value_errors = 0;
		missing_errors = 0;
		other_errors = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Calls from the stimulus side

	task expect_response(input string name, input logic is_read, input logic [1:0] resp,
		input logic [31:0] data, input logic [31:0] mask);
		exp_name = name;
		exp_is_read = is_read;
		exp_resp = resp;
		exp_data = data;
		// Zero mask checks resp only
		exp_mask = mask;
		pending <= 1'b1;
		wait_cycles <= 0;
	endtask

	task report_failure(input string msg);
		$display("%s", msg);
		other_errors++;
	endtask

	task check_response(input logic [1:0] resp, input logic [31:0] data);
		if (resp !== exp_resp || (data & exp_mask) !== (exp_data & exp_mask)) begin
			$display("ERR %s: expected resp %0d data %08h, actual resp %0d data %08h",
				exp_name, exp_resp, exp_data & exp_mask, resp, data & exp_mask);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Response monitor

	always @(posedge lane0_rxclk) begin
		if (arst_n) begin
			// B channel
			if (bvalid && bready) begin
				if (!pending || exp_is_read) begin
					report_failure("Write response arrived while no write was outstanding");
				end else begin
					check_response(bresp, 32'h0);
					pending <= 1'b0;
				end
			end
			// R channel
			if (rvalid && rready) begin
				if (!pending || !exp_is_read) begin
					report_failure("Read response arrived while no read was outstanding");
				end else begin
					check_response(rresp, rdata);
					last_rdata <= rdata;
					pending <= 1'b0;
				end
			end
			// Response that never shows up
			if (pending && !(bvalid && bready) && !(rvalid && rready)) begin
				if (wait_cycles == RESP_LIMIT) begin
					$display("%s: no response came back within %0d cycles",
						exp_name, RESP_LIMIT);
					missing_errors++;
					pending <= 1'b0;
				end else begin
					wait_cycles <= wait_cycles + 1;
				end
			end
		end
	end

endmodule

/* tb_top.sv */
`timescale 1ns/10ps

module tb_top;

	localparam int DEPTH = bert_pkg::DEF_CAPTURE_DEPTH;
	localparam int CAP_BLOCKS = DEPTH / 2;
	localparam int NUM_DATA = 2 * CAP_BLOCKS;
	localparam int MAX_OPS = 24;
	localparam int POLL_LIMIT = 600;
	localparam logic [63:0] IDLE_PAYLOAD = 64'h0000_0000_0000_001e;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	// Table operation kinds
	localparam int OP_RD = 0;
	localparam int OP_WR = 1;
	localparam int OP_POLL = 2;
	localparam int OP_IDLE = 3;
	localparam int OP_SEND = 4;
	localparam int OP_CAP = 5;

	logic lane0_rxclk;
	logic arst_n;
	logic [31:0] rx_data;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// Operation table with one row per step
	int op_kind [MAX_OPS];
	logic [7:0] op_addr [MAX_OPS];
	logic [31:0] op_data [MAX_OPS];
	logic [1:0] op_resp [MAX_OPS];
	logic [31:0] op_mask [MAX_OPS];
	string op_name [MAX_OPS];
	int num_ops;

	// Payloads of the header 01 blocks for two captures
	logic [63:0] data_payload [NUM_DATA];
	logic [31:0] rng;
	// Line scrambler with the newest bit at index 0
	logic [57:0] scr_state;
	bit line_bits [$];
	int send_q [$];
	int data_sent;
	int idle_sent;
	logic enc_run;
	int cycle_count;
	int cycle_limit;
	int run_errors;
	int i;

	bert_rx_top #(
		.CAPTURE_DEPTH(DEPTH),
		.LOCK_COUNT(bert_pkg::DEF_LOCK_COUNT),
		.BAD_LIMIT(bert_pkg::DEF_BAD_LIMIT),
		.SLIP_WAIT(bert_pkg::DEF_SLIP_WAIT)
	) u_dut (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	tb_checker #(.RESP_LIMIT(40)) u_chk (
		.lane0_rxclk(lane0_rxclk),
		.arst_n(arst_n),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.rvalid(rvalid),
		.rready(rready),
		.rresp(rresp),
		.rdata(rdata)
	);

	initial begin
		lane0_rxclk = 1'b0;
		forever #5 lane0_rxclk = ~lane0_rxclk;
	end

	function logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Line encoder model

	// Scrambler x^58 + x^39 + 1 starting with payload bit 0
	task encode_block(input logic [1:0] hdr, input logic [63:0] clear);
		logic [63:0] scr;
		int b;
		for (b = 0; b < 64; b++) begin
			scr[b] = clear[b] ^ scr_state[38] ^ scr_state[57];
			scr_state = {scr_state[56:0], scr[b]};
		end
		// Line order follows the block word with the MSB first
		line_bits.push_back(hdr[1]);
		line_bits.push_back(hdr[0]);
		for (b = 63; b >= 0; b--) begin
			line_bits.push_back(scr[b]);
		end
	endtask

	// Idle blocks fill every gap between queued data blocks
	always @(posedge lane0_rxclk) begin : line_encoder
		logic [31:0] word;
		int idx;
		int b;
		if (enc_run) begin
			while (line_bits.size() < 32) begin
				if (send_q.size() > 0) begin
					idx = send_q.pop_front();
					encode_block(2'b01, data_payload[idx]);
					data_sent++;
				end else begin
					encode_block(2'b10, IDLE_PAYLOAD);
					idle_sent++;
				end
			end
			for (b = 0; b < 32; b++) begin
				word[31 - b] = line_bits.pop_front();
			end
			rx_data <= word;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite driver

	task axi_write(input string name, input logic [7:0] addr, input logic [31:0] data,
		input logic [1:0] resp);
		u_chk.expect_response(name, 1'b0, resp, 32'h0, 32'h0);
		@(posedge lane0_rxclk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge lane0_rxclk);
		while (!awready && !wready && u_chk.pending) @(posedge lane0_rxclk);
		// Slave takes AW and W in the same cycle
		if (awready !== wready) begin
			u_chk.report_failure($sformatf("%s: AW and W were not accepted together", name));
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		while (u_chk.pending) @(posedge lane0_rxclk);
	endtask

	task axi_read(input string name, input logic [7:0] addr, input logic [1:0] resp,
		input logic [31:0] data, input logic [31:0] mask);
		u_chk.expect_response(name, 1'b1, resp, data, mask);
		@(posedge lane0_rxclk);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge lane0_rxclk);
		while (!arready && u_chk.pending) @(posedge lane0_rxclk);
		arvalid <= 1'b0;
		while (u_chk.pending) @(posedge lane0_rxclk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table

	task add_op(input int kind, input logic [7:0] addr, input logic [31:0] data,
		input logic [1:0] resp, input logic [31:0] mask, input string name);
		op_kind[num_ops] = kind;
		op_addr[num_ops] = addr;
		op_data[num_ops] = data;
		op_resp[num_ops] = resp;
		op_mask[num_ops] = mask;
		op_name[num_ops] = name;
		num_ops++;
	endtask

	// Status is {done, armed, lock}
	// Idle and send rows count blocks
	task load_table();
		num_ops = 0;
		add_op(OP_RD, bert_pkg::REG_STATUS, 0, OKAY, 32'hffff_ffff, "status after reset");
		add_op(OP_IDLE, 8'h00, 200, OKAY, 0, "idle blocks");
		add_op(OP_POLL, bert_pkg::REG_STATUS, 1, OKAY, 1, "block lock");
		add_op(OP_WR, bert_pkg::REG_CTRL, 1, OKAY, 0, "arm");
		add_op(OP_RD, bert_pkg::REG_STATUS, 3, OKAY, 7, "armed on idle");
		add_op(OP_IDLE, 8'h00, 8, OKAY, 0, "more idle blocks");
		add_op(OP_RD, bert_pkg::REG_STATUS, 3, OKAY, 7, "still armed on idle");
		add_op(OP_SEND, 8'h00, 0, OKAY, 0, "first data blocks");
		add_op(OP_IDLE, 8'h00, 4, OKAY, 0, "first flush");
		add_op(OP_RD, bert_pkg::REG_STATUS, 5, OKAY, 7, "first capture done");
		add_op(OP_CAP, 8'h00, 0, OKAY, 0, "first capture");
		add_op(OP_RD, 8'h40, 0, SLVERR, 0, "unmapped read");
		add_op(OP_WR, bert_pkg::CAPTURE_BASE, 32'hdead_beef, SLVERR, 0, "capture write");
		// Gap between the registers and the capture window
		add_op(OP_RD, 8'h08, 0, SLVERR, 0, "read past registers");
		add_op(OP_WR, bert_pkg::REG_CTRL, 1, OKAY, 0, "rearm");
		add_op(OP_RD, bert_pkg::REG_STATUS, 3, OKAY, 7, "rearm clears done");
		add_op(OP_SEND, 8'h00, CAP_BLOCKS, OKAY, 0, "second data blocks");
		add_op(OP_IDLE, 8'h00, 4, OKAY, 0, "second flush");
		add_op(OP_RD, bert_pkg::REG_STATUS, 5, OKAY, 7, "second capture done");
		add_op(OP_CAP, 8'h00, CAP_BLOCKS, OKAY, 0, "second capture");
	endtask

	// Budget of 40 cycles per block and 50 per bus operation plus 2000
	function int compute_limit();
		int blocks;
		int ops;
		int n;
		blocks = 0;
		ops = 0;
		for (n = 0; n < num_ops; n++) begin
			if (op_kind[n] == OP_IDLE) begin
				blocks += op_data[n];
			end else if (op_kind[n] == OP_SEND) begin
				blocks += CAP_BLOCKS;
			end else if (op_kind[n] == OP_CAP) begin
				ops += DEPTH;
			end else begin
				ops += 1;
			end
		end
		return 40 * blocks + 50 * ops + 2000;
	endfunction

	task run_op(input int n);
		int polls;
		int k;
		int target;
		logic [63:0] pl;
		logic [31:0] exp_word;
		case (op_kind[n])
			OP_RD: axi_read(op_name[n], op_addr[n], op_resp[n], op_data[n], op_mask[n]);
			OP_WR: axi_write(op_name[n], op_addr[n], op_data[n], op_resp[n]);
			OP_POLL: begin
				polls = 0;
				do begin
					axi_read(op_name[n], op_addr[n], op_resp[n], 32'h0, 32'h0);
					polls++;
				end while ((u_chk.last_rdata & op_mask[n]) !== op_data[n] && polls < POLL_LIMIT);
				if ((u_chk.last_rdata & op_mask[n]) !== op_data[n]) begin
					u_chk.report_failure($sformatf("%s: status never showed %08h after %0d reads",
						op_name[n], op_data[n], polls));
				end
			end
			OP_IDLE: begin
				@(negedge lane0_rxclk);
				target = idle_sent + op_data[n];
				while (idle_sent < target) @(negedge lane0_rxclk);
			end
			OP_SEND: begin
				@(negedge lane0_rxclk);
				target = data_sent + CAP_BLOCKS;
				for (k = 0; k < CAP_BLOCKS; k++) begin
					send_q.push_back(op_data[n] + k);
				end
				while (data_sent < target) @(negedge lane0_rxclk);
			end
			OP_CAP: begin
				// Two words per block with the low half first
				for (k = 0; k < DEPTH; k++) begin
					pl = data_payload[op_data[n] + k / 2];
					exp_word = (k % 2 == 1) ? pl[63:32] : pl[31:0];
					axi_read($sformatf("%s word %0d", op_name[n], k),
						bert_pkg::CAPTURE_BASE + 8'(4 * k), OKAY, exp_word, 32'hffff_ffff);
				end
			end
			default: u_chk.report_failure($sformatf("Row %0d has an unknown kind", n));
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		arst_n = 1'b0;
		rx_data = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		data_sent = 0;
		idle_sent = 0;
		enc_run = 1'b0;
		cycle_limit = 0;
		rng = 32'd74189;
		for (i = 0; i < NUM_DATA; i++) begin
			rng = xorshift(rng);
			data_payload[i][31:0] = rng;
			rng = xorshift(rng);
			data_payload[i][63:32] = rng;
		end
		// Scrambler must not start all zero
		rng = xorshift(rng);
		scr_state = {rng[25:0], rng} | 58'h1;
		// Random bit offset ahead of the first block
		rng = xorshift(rng);
		for (i = 0; i < rng % 66; i++) begin
			line_bits.push_back(xorshift(rng + i) & 1);
		end
		load_table();
		cycle_limit = compute_limit();
		enc_run = 1'b1;
		repeat (4) @(posedge lane0_rxclk);
		arst_n <= 1'b1;
		for (i = 0; i < num_ops; i++) begin
			run_op(i);
		end
		@(posedge lane0_rxclk);
		run_errors = u_chk.value_errors + u_chk.missing_errors + u_chk.other_errors;
		$display("Errors: %0d wrong value, %0d missing response, %0d other",
			u_chk.value_errors, u_chk.missing_errors, u_chk.other_errors);
		if (run_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Run limit
	initial begin
		cycle_count = 0;
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge lane0_rxclk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
		$display("Errors: %0d wrong value, %0d missing response, %0d other",
			u_chk.value_errors, u_chk.missing_errors, u_chk.other_errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* flist.f */
bert_pkg.sv
rx_gearbox.sv
block_aligner.sv
descrambler.sv
la_capture.sv
capture_ram_arbiter.sv
axil_regs.sv
bert_rx_top.sv
tb_checker.sv
tb_top.sv
